// File: logic/priv_types_pkg.sv
// Machine-mode trap unit shared types, cause codes and CSR addresses
`default_nettype none

package priv_types_pkg;

  // ****************************************
  // Basic vector types
  // ****************************************
  typedef logic [31:0] word_t;     // PCs, CSR data, fault addresses
  typedef logic [11:0] csr_addr_t; // CSR address space

  // ****************************************
  // Cause codes
  // ****************************************

  // Synchronous exceptions, mcause with interrupt bit 0
  typedef enum logic [3:0] {
    INSN_MAL     = 4'd0,
    INSN_FAULT   = 4'd1,
    ILLEGAL_INSN = 4'd2,
    BREAKPOINT   = 4'd3,
    L_ADDR_MAL   = 4'd4,
    L_FAULT      = 4'd5,
    S_ADDR_MAL   = 4'd6,
    S_FAULT      = 4'd7,
    ENV_CALL_M   = 4'd11
  } ex_code_t;

  // Machine-level interrupts, mcause with interrupt bit 1
  typedef enum logic [3:0] {
    SOFT_INT  = 4'd3,
    TIMER_INT = 4'd7,
    EXT_INT   = 4'd11
  } int_code_t;

  // ****************************************
  // CSR addresses, machine trap setup/handling
  // ****************************************
  localparam csr_addr_t CSR_MSTATUS = 12'h300;
  localparam csr_addr_t CSR_MIE     = 12'h304;
  localparam csr_addr_t CSR_MTVEC   = 12'h305;
  localparam csr_addr_t CSR_MEPC    = 12'h341;
  localparam csr_addr_t CSR_MCAUSE  = 12'h342;
  localparam csr_addr_t CSR_MTVAL   = 12'h343;
  localparam csr_addr_t CSR_MIP     = 12'h344;

  // Bit positions inside mstatus, mie and mip
  localparam int unsigned MIE_BIT  = 3;  // mstatus.MIE
  localparam int unsigned MSIP_BIT = 3;  // mip.MSIP, also mie.MSIE
  localparam int unsigned MTIP_BIT = 7;  // mip.MTIP, also mie.MTIE

endpackage

`default_nettype wire

// File: logic/priv_trap_control.sv
// Trap control, exception/interrupt priority and trap CSR update strobes
`default_nettype none
`timescale 1ns/1ps

module priv_trap_control import priv_types_pkg::*; (
  input  wire logic       CLK,
  input  wire logic       nRST,
  // Exception levels, held until pipe_clear
  input  wire logic       fault_l,
  input  wire logic       mal_l,
  input  wire logic       fault_s,
  input  wire logic       mal_s,
  input  wire logic       breakpoint,
  input  wire logic       env_m,
  input  wire logic       illegal_insn,
  input  wire logic       fault_insn,
  input  wire logic       mal_insn,
  // Interrupt levels
  input  wire logic       timer_int,
  input  wire logic       soft_int,
  input  wire logic       ext_int,
  input  wire logic       clear_timer_int,
  // Pipeline strobes and trap data
  input  wire logic       pipe_clear,
  input  wire logic       ret,
  input  wire word_t      epc,
  input  wire word_t      fault_addr,
  // Current CSR state
  input  wire logic       mstatus_mie,
  input  wire logic       mie_mtie,
  input  wire logic       mie_msie,
  input  wire logic       mip_mtip,
  input  wire logic       mip_msip,
  // CSR update strobes and next values
  output logic            mip_rup,
  output logic            mip_next_mtip,
  output logic            mip_next_msip,
  output logic            mcause_rup,
  output logic            mcause_next_int,
  output logic [3:0]      mcause_next_code,
  output logic            mstatus_rup,
  output logic            mstatus_next_mie,
  output logic            mepc_rup,
  output word_t           mepc_next,
  output logic            mtval_rup,
  output word_t           mtval_next,
  // To pipeline
  output logic            intr
);

  ex_code_t  ex_src;
  int_code_t intr_src;
  logic      exception;
  logic      interrupt_fired;  // Enabled and pending this cycle
  logic      interrupt_reg;    // Fired interrupt, held for the pipeline
  logic      trap;
  logic      tval_class;       // Exceptions that report an address

  // ****************************************
  // Exception priority
  // ****************************************
  always_comb begin
    exception = 1'b1;
    ex_src    = INSN_MAL;
    if (fault_l)           ex_src = L_FAULT;     // Highest
    else if (mal_l)        ex_src = L_ADDR_MAL;
    else if (fault_s)      ex_src = S_FAULT;
    else if (mal_s)        ex_src = S_ADDR_MAL;
    else if (breakpoint)   ex_src = BREAKPOINT;
    else if (env_m)        ex_src = ENV_CALL_M;
    else if (illegal_insn) ex_src = ILLEGAL_INSN;
    else if (fault_insn)   ex_src = INSN_FAULT;
    else if (mal_insn)     ex_src = INSN_MAL;    // Lowest
    else                   exception = 1'b0;
  end

  // ****************************************
  // Interrupt selection
  // ****************************************
  // Timer is taken from mip since timer_int may only pulse
  always_comb begin
    if (mie_mtie && mip_mtip) intr_src = TIMER_INT;
    else if (soft_int)        intr_src = SOFT_INT;
    else if (ext_int)         intr_src = EXT_INT;
    else                      intr_src = SOFT_INT;  // MSIP still pending
  end

  assign interrupt_fired = mstatus_mie & ((mie_mtie & mip_mtip) | (mie_msie & mip_msip));

  // Pending bits, external requests share MSIP
  assign mip_rup = timer_int | soft_int | ext_int | clear_timer_int;
  assign mip_next_mtip = clear_timer_int ? 1'b0 : (timer_int | mip_mtip);
  assign mip_next_msip = soft_int | ext_int | mip_msip;

  // Latch the interrupt, MIE drops right after it fires
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      interrupt_reg <= 1'b0;
    end else if (interrupt_fired) begin
      interrupt_reg <= 1'b1;
    end else if (pipe_clear) begin
      interrupt_reg <= 1'b0;   // Pipeline has flushed
    end
  end

  assign intr = exception | interrupt_reg;
  assign trap = exception | interrupt_fired;

  // ****************************************
  // Trap CSR updates
  // ****************************************
  assign mcause_rup       = trap;
  assign mcause_next_int  = ~exception;  // Exception wins over interrupt
  assign mcause_next_code = exception ? ex_src : intr_src;

  assign mepc_rup  = trap;
  assign mepc_next = epc;

  // Return also rewrites MIE
  assign mstatus_rup = trap | ret;
  always_comb begin
    if (intr || interrupt_fired) mstatus_next_mie = 1'b0;
    else if (ret)                mstatus_next_mie = 1'b1;
    else                         mstatus_next_mie = mstatus_mie;
  end

  // Breakpoint and ecall leave mtval alone
  assign tval_class = mal_l | fault_l | mal_s | fault_s
                    | illegal_insn | fault_insn | mal_insn;
  assign mtval_rup  = tval_class & pipe_clear;
  assign mtval_next = fault_addr;

endmodule

`default_nettype wire

// File: logic/priv_csr_file.sv
// Machine trap CSR file with software access and trap redirect PC
`default_nettype none
`timescale 1ns/1ps

module priv_csr_file import priv_types_pkg::*; #(
  parameter word_t RESET_MTVEC = 32'h0000_0000
) (
  input  wire logic       CLK,
  input  wire logic       nRST,
  // Trap updates
  input  wire logic       mip_rup,
  input  wire logic       mip_next_mtip,
  input  wire logic       mip_next_msip,
  input  wire logic       mcause_rup,
  input  wire logic       mcause_next_int,
  input  wire logic [3:0] mcause_next_code,
  input  wire logic       mstatus_rup,
  input  wire logic       mstatus_next_mie,
  input  wire logic       mepc_rup,
  input  wire word_t      mepc_next,
  input  wire logic       mtval_rup,
  input  wire word_t      mtval_next,
  // Software access
  input  wire logic       csr_wr,
  input  wire csr_addr_t  csr_addr,
  input  wire word_t      csr_wdata,
  output word_t           csr_rdata,
  // Pipeline control
  input  wire logic       intr,
  input  wire logic       ret,
  output word_t           redirect_pc,
  // Current state to trap control
  output logic            mstatus_mie,
  output logic            mie_mtie,
  output logic            mie_msie,
  output logic            mip_mtip,
  output logic            mip_msip
);

  logic       mcause_int;
  logic [3:0] mcause_code;
  word_t      mepc;
  word_t      mtval;
  word_t      mtvec;

  // Per-register software write enables
  logic wr_mstatus, wr_mie, wr_mip, wr_mcause, wr_mepc, wr_mtval, wr_mtvec;

  assign wr_mstatus = csr_wr && (csr_addr == CSR_MSTATUS);
  assign wr_mie     = csr_wr && (csr_addr == CSR_MIE);
  assign wr_mip     = csr_wr && (csr_addr == CSR_MIP);
  assign wr_mcause  = csr_wr && (csr_addr == CSR_MCAUSE);
  assign wr_mepc    = csr_wr && (csr_addr == CSR_MEPC) && !ret;  // Return target in use
  assign wr_mtval   = csr_wr && (csr_addr == CSR_MTVAL);
  assign wr_mtvec   = csr_wr && (csr_addr == CSR_MTVEC);

  // ****************************************
  // Registers, trap update before software
  // ****************************************
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      mstatus_mie <= 1'b0;          // Interrupts off out of reset
      mie_mtie    <= 1'b0;
      mie_msie    <= 1'b0;
      mip_mtip    <= 1'b0;
      mip_msip    <= 1'b0;
      mcause_int  <= 1'b0;
      mcause_code <= '0;
      mepc        <= '0;
      mtval       <= '0;
      mtvec       <= RESET_MTVEC;
    end else begin
      if (mstatus_rup)     mstatus_mie <= mstatus_next_mie;
      else if (wr_mstatus) mstatus_mie <= csr_wdata[MIE_BIT];

      if (wr_mie) begin  // Only software touches mie
        mie_mtie <= csr_wdata[MTIP_BIT];
        mie_msie <= csr_wdata[MSIP_BIT];
      end

      // MTIP is read-only to software
      if (mip_rup) begin
        mip_mtip <= mip_next_mtip;
        mip_msip <= mip_next_msip;
      end else if (wr_mip) begin
        mip_msip <= csr_wdata[MSIP_BIT];
      end

      if (mcause_rup) begin
        mcause_int  <= mcause_next_int;
        mcause_code <= mcause_next_code;
      end else if (wr_mcause) begin
        mcause_int  <= csr_wdata[31];
        mcause_code <= csr_wdata[3:0];
      end

      if (mepc_rup)     mepc <= mepc_next;
      else if (wr_mepc) mepc <= {csr_wdata[31:2], 2'b00};  // Word aligned

      if (mtval_rup)     mtval <= mtval_next;
      else if (wr_mtval) mtval <= csr_wdata;

      if (wr_mtvec) mtvec <= csr_wdata;  // Mode bits kept, direct only
    end
  end

  // ****************************************
  // Read decode
  // ****************************************
  always_comb begin
    csr_rdata = '0;  // Unknown addresses read zero
    case (csr_addr)
      CSR_MSTATUS: csr_rdata[MIE_BIT] = mstatus_mie;
      CSR_MIE: begin
        csr_rdata[MTIP_BIT] = mie_mtie;
        csr_rdata[MSIP_BIT] = mie_msie;
      end
      CSR_MIP: begin
        csr_rdata[MTIP_BIT] = mip_mtip;
        csr_rdata[MSIP_BIT] = mip_msip;
      end
      CSR_MCAUSE: csr_rdata = {mcause_int, 27'd0, mcause_code};
      CSR_MEPC:   csr_rdata = mepc;
      CSR_MTVAL:  csr_rdata = mtval;
      CSR_MTVEC:  csr_rdata = mtvec;
      default:    csr_rdata = '0;
    endcase
  end

  // Trap goes to the handler base, anything else returns to mepc
  assign redirect_pc = intr ? {mtvec[31:2], 2'b00} : mepc;

endmodule

`default_nettype wire

// File: logic/priv_unit.sv
// Machine-mode trap unit top, trap control beside the trap CSR file
`default_nettype none
`timescale 1ns/1ps

module priv_unit import priv_types_pkg::*; #(
  parameter word_t RESET_MTVEC = 32'h0000_0000
) (
  input  wire logic      CLK,
  input  wire logic      nRST,
  // Exception levels
  input  wire logic      fault_l,
  input  wire logic      mal_l,
  input  wire logic      fault_s,
  input  wire logic      mal_s,
  input  wire logic      breakpoint,
  input  wire logic      env_m,
  input  wire logic      illegal_insn,
  input  wire logic      fault_insn,
  input  wire logic      mal_insn,
  // Interrupt levels
  input  wire logic      timer_int,
  input  wire logic      soft_int,
  input  wire logic      ext_int,
  input  wire logic      clear_timer_int,
  // Trap data and strobes
  input  wire word_t     epc,
  input  wire word_t     fault_addr,
  input  wire logic      pipe_clear,
  input  wire logic      ret,
  input  wire logic      csr_wr,
  // CSR access
  input  wire csr_addr_t csr_addr,
  input  wire word_t     csr_wdata,
  output word_t          csr_rdata,
  // To pipeline
  output logic           intr,
  output word_t          redirect_pc
);

  // ****************************************
  // Control to CSR file
  // ****************************************
  logic       mip_rup, mip_next_mtip, mip_next_msip;
  logic       mcause_rup, mcause_next_int;
  logic [3:0] mcause_next_code;
  logic       mstatus_rup, mstatus_next_mie;
  logic       mepc_rup, mtval_rup;
  word_t      mepc_next, mtval_next;

  // CSR state back to control
  logic mstatus_mie, mie_mtie, mie_msie, mip_mtip, mip_msip;

  priv_trap_control priv_trap_control_i (
    .CLK, .nRST,
    .fault_l, .mal_l, .fault_s, .mal_s, .breakpoint, .env_m,
    .illegal_insn, .fault_insn, .mal_insn,
    .timer_int, .soft_int, .ext_int, .clear_timer_int,
    .pipe_clear, .ret, .epc, .fault_addr,
    .mstatus_mie, .mie_mtie, .mie_msie, .mip_mtip, .mip_msip,
    .mip_rup, .mip_next_mtip, .mip_next_msip,
    .mcause_rup, .mcause_next_int, .mcause_next_code,
    .mstatus_rup, .mstatus_next_mie,
    .mepc_rup, .mepc_next, .mtval_rup, .mtval_next,
    .intr
  );

  priv_csr_file #(
    .RESET_MTVEC(RESET_MTVEC)
  ) priv_csr_file_i (
    .CLK, .nRST,
    .mip_rup, .mip_next_mtip, .mip_next_msip,
    .mcause_rup, .mcause_next_int, .mcause_next_code,
    .mstatus_rup, .mstatus_next_mie,
    .mepc_rup, .mepc_next, .mtval_rup, .mtval_next,
    .csr_wr, .csr_addr, .csr_wdata, .csr_rdata,
    .intr, .ret, .redirect_pc,
    .mstatus_mie, .mie_mtie, .mie_msie, .mip_mtip, .mip_msip
  );

endmodule

`default_nettype wire

// File: testbench/priv_unit_asserts.sv
// Trap control checks on exception response, interrupt latch and CSR strobes
`default_nettype none
`timescale 1ns/1ps

module priv_unit_asserts (
  input wire logic CLK,
  input wire logic nRST,
  input wire logic fault_l,
  input wire logic mal_l,
  input wire logic fault_s,
  input wire logic mal_s,
  input wire logic breakpoint,
  input wire logic env_m,
  input wire logic illegal_insn,
  input wire logic fault_insn,
  input wire logic mal_insn,
  input wire logic pipe_clear,
  input wire logic interrupt_reg,  // Latched interrupt inside trap control
  input wire logic intr,
  input wire logic mcause_rup,
  input wire logic mepc_rup
);

  logic exc_any;  // Any synchronous exception level

  assign exc_any = fault_l | mal_l | fault_s | mal_s | breakpoint | env_m
                 | illegal_insn | fault_insn | mal_insn;

  // ****************************************
  // Properties
  // ****************************************
  exc_gives_intr: assert property (@(posedge CLK) disable iff (!nRST) exc_any |-> intr)
    else $error("exception level high without intr");

  // Latch only drops on a pipeline flush
  latch_holds: assert property (@(posedge CLK) disable iff (!nRST)
                                interrupt_reg && !pipe_clear |=> interrupt_reg)
    else $error("interrupt latch dropped without pipe_clear");

  cause_with_epc: assert property (@(posedge CLK) disable iff (!nRST) mcause_rup |-> mepc_rup)
    else $error("mcause update without mepc update");

endmodule

bind priv_trap_control priv_unit_asserts priv_unit_asserts_i (
  .CLK(CLK), .nRST(nRST),
  .fault_l(fault_l), .mal_l(mal_l), .fault_s(fault_s), .mal_s(mal_s),
  .breakpoint(breakpoint), .env_m(env_m), .illegal_insn(illegal_insn),
  .fault_insn(fault_insn), .mal_insn(mal_insn),
  .pipe_clear(pipe_clear), .interrupt_reg(interrupt_reg), .intr(intr),
  .mcause_rup(mcause_rup), .mepc_rup(mepc_rup)
);

`default_nettype wire

// File: testbench/tb_priv_unit.sv
// Trap unit testbench with directed and random trap sequences checked by assertions
`default_nettype none
`timescale 1ns/1ps

module tb_priv_unit import priv_types_pkg::*; ();

  localparam word_t MTVEC_BASE = 32'h0000_0100;
  localparam int    PAIR_COUNT = 56;   // Random exception pairs, 3 cycles each
  localparam int    MAX_CYCLES = 400;  // Sequence runs near 200 cycles

  logic      CLK, nRST;
  logic      fault_l, mal_l, fault_s, mal_s, breakpoint, env_m;
  logic      illegal_insn, fault_insn, mal_insn;
  logic      timer_int, soft_int, ext_int, clear_timer_int;
  logic      pipe_clear, ret, csr_wr, intr;
  word_t     epc, fault_addr, csr_wdata, csr_rdata, redirect_pc;
  csr_addr_t csr_addr;

  integer seed;
  int     errors = 0;
  int     cycles = 0;
  logic   masked;  // MIE known clear, intr must stay low

  priv_unit #(.RESET_MTVEC(MTVEC_BASE)) priv_unit_i (.*);

  always #4 CLK = ~CLK;  // 8 ns period

  // ****************************************
  // Concurrent checks
  // ****************************************
  // mtvec never rewritten, trap target stays at reset base
  assert property (@(posedge CLK) disable iff (!nRST) intr |-> (redirect_pc == MTVEC_BASE))
    else begin
      errors++;
      $display("ERROR at %0t: redirect_pc is not the mtvec base while intr is high", $time);
    end

  assert property (@(posedge CLK) disable iff (!nRST) masked |-> !intr)
    else begin
      errors++;
      $display("ERROR at %0t: intr raised while MIE is clear", $time);
    end

  // ****************************************
  // Helpers
  // ****************************************
  task automatic next_cycle();
    @(posedge CLK);
    #1;  // Drive point
  endtask

  task automatic compare_word(input word_t got, input word_t exp, input string what);
    assert (got === exp) else begin
      errors++;
      $display("ERROR at %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_level(input logic got, input logic exp, input string what);
    assert (got === exp) else begin
      errors++;
      $display("ERROR at %0t: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  // Masked read of one CSR, settles within the current cycle
  task automatic read_csr(input csr_addr_t addr, input word_t mask, input word_t exp,
                          input string what);
    csr_addr = addr;
    #1;
    compare_word(csr_rdata & mask, exp, what);
  endtask

  task automatic csr_write(input csr_addr_t addr, input word_t data);
    next_cycle();
    csr_wr    = 1'b1;
    csr_addr  = addr;
    csr_wdata = data;
    next_cycle();
    csr_wr    = 1'b0;
  endtask

  // Bit 0 is the highest priority level
  task automatic drive_levels(input logic [8:0] lv);
    fault_l      = lv[0];
    mal_l        = lv[1];
    fault_s      = lv[2];
    mal_s        = lv[3];
    breakpoint   = lv[4];
    env_m        = lv[5];
    illegal_insn = lv[6];
    fault_insn   = lv[7];
    mal_insn     = lv[8];
  endtask

  function automatic logic [3:0] level_code(input int idx);
    case (idx)
      0:       level_code = L_FAULT;
      1:       level_code = L_ADDR_MAL;
      2:       level_code = S_FAULT;
      3:       level_code = S_ADDR_MAL;
      4:       level_code = BREAKPOINT;
      5:       level_code = ENV_CALL_M;
      6:       level_code = ILLEGAL_INSN;
      7:       level_code = INSN_FAULT;
      default: level_code = INSN_MAL;
    endcase
  endfunction

  // Walk up from lowest priority so the highest set level wins
  function automatic logic [3:0] top_code(input logic [8:0] lv);
    logic [3:0] code;
    code = 4'd0;
    for (int i = 8; i >= 0; i--) begin
      if (lv[i]) code = level_code(i);
    end
    return code;
  endfunction

  // Raise levels, check trap entry, then flush with pipe_clear
  task automatic take_exception(input logic [8:0] lv, output word_t addr);
    word_t      pc;
    logic [3:0] code;
    pc   = $random(seed);
    addr = $random(seed);
    code = top_code(lv);
    next_cycle();
    drive_levels(lv);
    epc        = pc;
    fault_addr = addr;
    #1;
    check_level(intr, 1'b1, "intr during exception");
    compare_word(redirect_pc, MTVEC_BASE, "redirect_pc on trap entry");
    next_cycle();
    pipe_clear = 1'b1;  // Levels still held this cycle
    read_csr(CSR_MCAUSE, 32'hffff_ffff, {28'd0, code}, "mcause after exception");
    read_csr(CSR_MEPC, 32'hffff_ffff, pc, "mepc after exception");
    read_csr(CSR_MSTATUS, 32'h8, 32'h0, "mstatus.MIE after exception");
    next_cycle();
    drive_levels(9'd0);
    pipe_clear = 1'b0;
  endtask

  // ****************************************
  // Stimulus
  // ****************************************
  initial begin
    word_t addr_a;
    word_t addr_b;
    int    a;
    int    b;
    seed = 32'h85aa36d5;
    CLK = 1'b0;
    nRST = 1'b0;
    masked = 1'b0;
    drive_levels(9'd0);
    {timer_int, soft_int, ext_int, clear_timer_int} = 4'b0;
    {pipe_clear, ret, csr_wr} = 3'b0;
    epc = '0;
    fault_addr = '0;
    csr_addr = CSR_MSTATUS;
    csr_wdata = '0;
    repeat (2) @(posedge CLK);
    #1;
    nRST = 1'b1;
    check_level(intr, 1'b0, "intr after reset");
    read_csr(CSR_MSTATUS, 32'h8, 32'h0, "mstatus.MIE after reset");
    read_csr(CSR_MTVEC, 32'hffff_ffff, MTVEC_BASE, "mtvec after reset");

    // Exception priority, two distinct levels at once
    for (int n = 0; n < PAIR_COUNT; n++) begin
      a = $unsigned($random(seed)) % 9;
      b = (a + 1 + $unsigned($random(seed)) % 8) % 9;
      take_exception((9'd1 << a) | (9'd1 << b), addr_a);
    end

    // Trap entry with MIE set first, ecall
    csr_write(CSR_MSTATUS, 32'h8);
    read_csr(CSR_MSTATUS, 32'h8, 32'h8, "MIE set by software");
    take_exception(9'b0_0010_0000, addr_a);

    // mtval, load fault writes it and breakpoint keeps it
    take_exception(9'b0_0000_0001, addr_a);
    read_csr(CSR_MTVAL, 32'hffff_ffff, addr_a, "mtval after load fault");
    take_exception(9'b0_0001_0000, addr_b);
    read_csr(CSR_MTVAL, 32'hffff_ffff, addr_a, "mtval after breakpoint");

    // Timer interrupt, MTIE then MIE
    csr_write(CSR_MIE, 32'h80);
    csr_write(CSR_MSTATUS, 32'h8);
    next_cycle();
    timer_int = 1'b1;
    epc = 32'h0000_1234;
    #1;
    check_level(intr, 1'b0, "intr in timer_int cycle");
    next_cycle();
    check_level(intr, 1'b0, "intr one cycle after timer_int");
    timer_int = 1'b0;
    next_cycle();
    check_level(intr, 1'b1, "intr two cycles after timer_int");
    read_csr(CSR_MCAUSE, 32'hffff_ffff, 32'h8000_0007, "mcause for timer interrupt");
    read_csr(CSR_MEPC, 32'hffff_ffff, 32'h0000_1234, "mepc for timer interrupt");
    repeat (3) begin
      next_cycle();
      check_level(intr, 1'b1, "intr held before pipe_clear");
    end
    read_csr(CSR_MIP, 32'h80, 32'h80, "mip.MTIP while pending");
    next_cycle();
    pipe_clear = 1'b1;
    clear_timer_int = 1'b1;
    next_cycle();
    pipe_clear = 1'b0;
    clear_timer_int = 1'b0;
    check_level(intr, 1'b0, "intr after pipe_clear");
    read_csr(CSR_MIP, 32'h80, 32'h0, "mip.MTIP after clear_timer_int");

    // Masked timer, MIE still clear from the trap
    masked = 1'b1;
    next_cycle();
    timer_int = 1'b1;
    next_cycle();
    timer_int = 1'b0;
    repeat (4) next_cycle();
    check_level(intr, 1'b0, "intr with MIE clear");
    read_csr(CSR_MIP, 32'h80, 32'h80, "mip.MTIP set while masked");
    next_cycle();
    clear_timer_int = 1'b1;
    next_cycle();
    clear_timer_int = 1'b0;
    read_csr(CSR_MIP, 32'h80, 32'h0, "mip.MTIP cleared while masked");
    masked = 1'b0;

    // Return to a software mepc
    csr_write(CSR_MEPC, 32'h0000_2468);
    read_csr(CSR_MEPC, 32'hffff_ffff, 32'h0000_2468, "mepc written by software");
    read_csr(CSR_MSTATUS, 32'h8, 32'h0, "MIE before return");
    next_cycle();
    ret = 1'b1;
    #1;
    compare_word(redirect_pc, 32'h0000_2468, "redirect_pc during ret");
    next_cycle();
    ret = 1'b0;
    read_csr(CSR_MSTATUS, 32'h8, 32'h8, "MIE after ret");
    check_level(intr, 1'b0, "intr after ret");

    repeat (2) next_cycle();
    $display("Summary: %0d errors after %0d cycles", errors, cycles);
    if (errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

  // Cycle limit guard
  always @(posedge CLK) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
      $display("SOME TESTS FAILED");
      $finish;
    end
  end

endmodule

`default_nettype wire

// File: priv_unit.f
logic/priv_types_pkg.sv
logic/priv_trap_control.sv
logic/priv_csr_file.sv
logic/priv_unit.sv
testbench/priv_unit_asserts.sv
testbench/tb_priv_unit.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the trap unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module tb_priv_unit \
  -f priv_unit.f \
  --Mdir "$BUILD_DIR" -o sim_priv_unit
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$BUILD_DIR/sim_priv_unit" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "SOME TESTS FAILED" "$LOG"; then
  echo "Result: FAIL"
  exit 1
fi

echo "Result: PASS"
exit 0
